//--- logic/fetch_pkg.sv
package fetch_pkg;

	//////////////////////////////
	// group geometry
	//////////////////////////////

	// instructions per fetch group
	localparam int GROUP_SLOTS = 4;
	localparam int INST_W = 16;

	// pc counts instructions, not bytes
	typedef logic [15:0] pc_t;
	typedef logic [INST_W-1:0] inst_t;
	// slot 0 sits in the low bits
	typedef inst_t [GROUP_SLOTS-1:0] group_t;

	//////////////////////////////
	// opcodes
	//////////////////////////////

	typedef logic [3:0] opcode_t;
	// conditional branch, low 8 bits signed offset from own pc
	localparam opcode_t OP_BRANCH = 4'hB;
	// immediate jump, low 12 bits replace pc[11:0]
	localparam opcode_t OP_JUMP = 4'hE;

	function automatic opcode_t op_of(inst_t inst);
		return inst[INST_W-1 -: 4];
	endfunction

	//////////////////////////////
	// prediction counters
	//////////////////////////////

	// 2 and 3 predict taken
	typedef logic [1:0] ctr_t;
	localparam ctr_t CTR_INIT = 2'd1;
	localparam ctr_t CTR_MAX = 2'd3;
	localparam ctr_t CTR_MIN = 2'd0;

endpackage

//--- logic/imem_apb_if.sv
`timescale 1ns/1ps

interface imem_apb_if #(
	parameter int IMEM_ADDR_W = 10
) ();
	import fetch_pkg::*;

	// requester side
	logic psel;
	logic penable;
	logic pwrite;
	logic [IMEM_ADDR_W-1:0] paddr;
	group_t pwdata;

	// completer side
	group_t prdata;
	logic pready;

	modport requester (
		output psel, penable, pwrite, paddr, pwdata,
		input prdata, pready
	);

	modport completer (
		input psel, penable, pwrite, paddr, pwdata,
		output prdata, pready
	);

endinterface

//--- logic/imem_arbiter.sv
`timescale 1ns/1ps

module imem_arbiter #(
	parameter int IMEM_ADDR_W = 10
) (
	input logic clk,
	input logic rst,
	imem_apb_if.completer host,
	imem_apb_if.completer fetch,
	imem_apb_if.requester mem
);
	import fetch_pkg::*;

	// bus held across setup and access
	logic owned;
	// 1 = fetch owns, 0 = host owns
	logic owner;
	// who finished the last transfer
	logic last_fetch;

	logic gnt_valid;
	logic gnt_fetch;
	logic [IMEM_ADDR_W-1:0] paddr_sel;
	group_t pwdata_sel;
	logic pwrite_sel;
	logic penable_sel;

	//////////////////////////////
	// grant
	//////////////////////////////

	always_comb begin
		gnt_valid = 1'b1;
		gnt_fetch = owner;
		if (!owned) begin
			if (host.psel && fetch.psel) begin
				// round robin, whoever waited
				gnt_fetch = !last_fetch;
			end else if (fetch.psel) begin
				gnt_fetch = 1'b1;
			end else if (host.psel) begin
				gnt_fetch = 1'b0;
			end else begin
				gnt_valid = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			owned <= 1'b0;
			owner <= 1'b0;
			// host goes first on a tie after reset
			last_fetch <= 1'b1;
		end else if (gnt_valid) begin
			if (mem.pready) begin
				owned <= 1'b0;
				last_fetch <= gnt_fetch;
			end else begin
				owned <= 1'b1;
				owner <= gnt_fetch;
			end
		end
	end

	//////////////////////////////
	// steering
	//////////////////////////////

	always_comb begin
		paddr_sel = gnt_fetch ? fetch.paddr : host.paddr;
		pwdata_sel = gnt_fetch ? fetch.pwdata : host.pwdata;
		pwrite_sel = gnt_fetch ? fetch.pwrite : host.pwrite;
		penable_sel = gnt_fetch ? fetch.penable : host.penable;
	end

	assign mem.psel = gnt_valid;
	// a late winner already has penable up, so the first owned cycle is the setup
	assign mem.penable = owned & penable_sel;
	assign mem.pwrite = gnt_valid & pwrite_sel;
	assign mem.paddr = gnt_valid ? paddr_sel : '0;
	assign mem.pwdata = gnt_valid ? pwdata_sel : '0;

	// loser sees nothing
	assign fetch.pready = gnt_valid & gnt_fetch & mem.pready;
	assign fetch.prdata = (gnt_valid && gnt_fetch) ? mem.prdata : '0;
	assign host.pready = gnt_valid & !gnt_fetch & mem.pready;
	assign host.prdata = (gnt_valid && !gnt_fetch) ? mem.prdata : '0;

endmodule

//--- logic/imem_bank.sv
`timescale 1ns/1ps

module imem_bank #(
	parameter int IMEM_ADDR_W = 10
) (
	input logic clk,
	input logic rst,
	imem_apb_if.completer bus
);
	import fetch_pkg::*;

	localparam int DEPTH = 2 ** IMEM_ADDR_W;

	// one aligned group per entry
	group_t mem [DEPTH];

	logic access;

	//////////////////////////////
	// zero wait completer
	//////////////////////////////

	// answers in the first access cycle
	assign access = bus.psel & bus.penable;
	assign bus.pready = access;

	// read data only while a read completes
	assign bus.prdata = (access && !bus.pwrite) ? mem[bus.paddr] : '0;

	// no writes land while in reset
	always_ff @(posedge clk) begin
		if (!rst && access && bus.pwrite) begin
			mem[bus.paddr] <= bus.pwdata;
		end
	end

endmodule

//--- logic/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
	parameter int PRED_ENTRIES = 64
) (
	input logic clk,
	input logic rst,
	input fetch_pkg::pc_t [fetch_pkg::GROUP_SLOTS-1:0] lookup_pc,
	output logic [fetch_pkg::GROUP_SLOTS-1:0] lookup_taken,
	input logic upd_en,
	input fetch_pkg::pc_t upd_pc,
	input logic upd_taken
);
	import fetch_pkg::*;

	localparam int IDX_W = $clog2(PRED_ENTRIES);

	// pattern table, indexed by low pc bits
	ctr_t table_q [PRED_ENTRIES];

	logic [IDX_W-1:0] upd_idx;
	ctr_t upd_ctr;

	//////////////////////////////
	// lookup
	//////////////////////////////

	// msb of the counter is the prediction
	always_comb begin
		for (int i = 0; i < GROUP_SLOTS; i++) begin
			lookup_taken[i] = table_q[lookup_pc[i][IDX_W-1:0]][1];
		end
	end

	//////////////////////////////
	// commit update
	//////////////////////////////

	assign upd_idx = upd_pc[IDX_W-1:0];
	assign upd_ctr = table_q[upd_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			// weakly not taken
			for (int i = 0; i < PRED_ENTRIES; i++) begin
				table_q[i] <= CTR_INIT;
			end
		end else if (upd_en) begin
			// saturate at both ends
			if (upd_taken && upd_ctr != CTR_MAX) begin
				table_q[upd_idx] <= upd_ctr + 2'd1;
			end else if (!upd_taken && upd_ctr != CTR_MIN) begin
				table_q[upd_idx] <= upd_ctr - 2'd1;
			end
		end
	end

endmodule

//--- logic/fetch_engine.sv
`timescale 1ns/1ps

module fetch_engine #(
	parameter int IMEM_ADDR_W = 10
) (
	input logic clk,
	input logic rst,
	imem_apb_if.requester bus,
	input fetch_pkg::pc_t exter_pc,
	input logic exter_pc_en,
	input logic has_mispredict,
	input fetch_pkg::pc_t pc_recovery,
	input logic stall_fetch,
	output fetch_pkg::pc_t [fetch_pkg::GROUP_SLOTS-1:0] lookup_pc,
	input logic [fetch_pkg::GROUP_SLOTS-1:0] lookup_taken,
	output logic group_valid,
	output fetch_pkg::pc_t pc_to_dec,
	output fetch_pkg::group_t inst_to_dec,
	output logic [fetch_pkg::GROUP_SLOTS-1:0] slot_valid,
	output logic [fetch_pkg::GROUP_SLOTS-1:0] pred_result_to_dec
);
	import fetch_pkg::*;

	logic running;
	pc_t pc;
	// read outstanding, doubles as psel
	logic rd_busy;
	logic rd_access;
	// result of the current read is stale
	logic discard;
	logic [IMEM_ADDR_W-1:0] paddr_q;

	logic redirect;
	logic start;
	logic accept;
	pc_t base;
	pc_t next_pc;
	logic [GROUP_SLOTS-1:0] slot_valid_c;
	logic [GROUP_SLOTS-1:0] pred_c;
	logic alive;
	pc_t slot_pc;
	inst_t slot_inst;

	assign redirect = exter_pc_en | has_mispredict;
	// wait while a group is held, launch when it leaves
	assign start = running & !rd_busy & !redirect & (!group_valid | !stall_fetch);
	assign accept = rd_busy & bus.pready & !discard & !redirect;
	assign base = {pc[15:2], 2'b00};

	// read only requester
	assign bus.psel = rd_busy;
	assign bus.penable = rd_access;
	assign bus.pwrite = 1'b0;
	assign bus.paddr = paddr_q;
	assign bus.pwdata = '0;

	//////////////////////////////
	// predecode
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < GROUP_SLOTS; i++) begin
			lookup_pc[i] = base | pc_t'(i);
		end
	end

	// first jump or taken branch at or above pc[1:0] ends the group
	always_comb begin
		alive = 1'b1;
		next_pc = {pc[15:2] + 14'd1, 2'b00};
		slot_valid_c = '0;
		pred_c = '0;
		slot_pc = base;
		slot_inst = '0;
		for (int i = 0; i < GROUP_SLOTS; i++) begin
			slot_pc = base | pc_t'(i);
			slot_inst = bus.prdata[i];
			if (alive && 2'(i) >= pc[1:0]) begin
				slot_valid_c[i] = 1'b1;
				if (op_of(slot_inst) == OP_BRANCH && lookup_taken[i]) begin
					pred_c[i] = 1'b1;
					next_pc = slot_pc + {{8{slot_inst[7]}}, slot_inst[7:0]};
					alive = 1'b0;
				end else if (op_of(slot_inst) == OP_JUMP) begin
					next_pc = {slot_pc[15:12], slot_inst[11:0]};
					alive = 1'b0;
				end
			end
		end
	end

	//////////////////////////////
	// pc, bus and decode regs
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			pc <= '0;
			rd_busy <= 1'b0;
			rd_access <= 1'b0;
			discard <= 1'b0;
			group_valid <= 1'b0;
		end else begin
			// decode took it
			if (group_valid && !stall_fetch) begin
				group_valid <= 1'b0;
			end
			if (rd_busy) begin
				rd_access <= 1'b1;
				if (bus.pready) begin
					rd_busy <= 1'b0;
					rd_access <= 1'b0;
					discard <= 1'b0;
				end
			end else if (start) begin
				rd_busy <= 1'b1;
				paddr_q <= pc[IMEM_ADDR_W+1:2];
			end
			if (redirect) begin
				// external load wins over recovery
				pc <= exter_pc_en ? exter_pc : pc_recovery;
				group_valid <= 1'b0;
				if (exter_pc_en) begin
					running <= 1'b1;
				end
				// in-flight read finishes but is dropped
				if (rd_busy && !bus.pready) begin
					discard <= 1'b1;
				end
			end else if (accept) begin
				group_valid <= 1'b1;
				pc <= next_pc;
			end
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (accept) begin
			pc_to_dec <= base;
			inst_to_dec <= bus.prdata;
			slot_valid <= slot_valid_c;
			pred_result_to_dec <= pred_c;
		end
	end

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
	parameter int IMEM_ADDR_W = 10,
	parameter int PRED_ENTRIES = 64
) (
	input logic clk,
	input logic rst,
	// host program port
	input logic host_psel,
	input logic host_penable,
	input logic host_pwrite,
	input logic [IMEM_ADDR_W-1:0] host_paddr,
	input fetch_pkg::group_t host_pwdata,
	output fetch_pkg::group_t host_prdata,
	output logic host_pready,
	// redirects
	input fetch_pkg::pc_t exter_pc,
	input logic exter_pc_en,
	input logic has_mispredict,
	input fetch_pkg::pc_t pc_recovery,
	// commit side counter update
	input logic upd_en,
	input fetch_pkg::pc_t upd_pc,
	input logic upd_taken,
	input logic stall_fetch,
	// to decode
	output logic group_valid,
	output fetch_pkg::pc_t pc_to_dec,
	output fetch_pkg::group_t inst_to_dec,
	output logic [fetch_pkg::GROUP_SLOTS-1:0] slot_valid,
	output logic [fetch_pkg::GROUP_SLOTS-1:0] pred_result_to_dec
);

	fetch_pkg::pc_t [fetch_pkg::GROUP_SLOTS-1:0] lookup_pc;
	logic [fetch_pkg::GROUP_SLOTS-1:0] lookup_taken;

	imem_apb_if #(.IMEM_ADDR_W(IMEM_ADDR_W)) host_bus ();
	imem_apb_if #(.IMEM_ADDR_W(IMEM_ADDR_W)) fetch_bus ();
	imem_apb_if #(.IMEM_ADDR_W(IMEM_ADDR_W)) mem_bus ();

	//////////////////////////////
	// host port onto its bus
	//////////////////////////////

	assign host_bus.psel = host_psel;
	assign host_bus.penable = host_penable;
	assign host_bus.pwrite = host_pwrite;
	assign host_bus.paddr = host_paddr;
	assign host_bus.pwdata = host_pwdata;
	assign host_prdata = host_bus.prdata;
	assign host_pready = host_bus.pready;

	imem_arbiter #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_arbiter (
		.clk (clk),
		.rst (rst),
		.host (host_bus.completer),
		.fetch (fetch_bus.completer),
		.mem (mem_bus.requester)
	);

	imem_bank #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_bank (
		.clk (clk),
		.rst (rst),
		.bus (mem_bus.completer)
	);

	branch_predictor #(.PRED_ENTRIES(PRED_ENTRIES)) u_predictor (
		.clk (clk),
		.rst (rst),
		.lookup_pc (lookup_pc),
		.lookup_taken (lookup_taken),
		.upd_en (upd_en),
		.upd_pc (upd_pc),
		.upd_taken (upd_taken)
	);

	fetch_engine #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_engine (
		.clk (clk),
		.rst (rst),
		.bus (fetch_bus.requester),
		.exter_pc (exter_pc),
		.exter_pc_en (exter_pc_en),
		.has_mispredict (has_mispredict),
		.pc_recovery (pc_recovery),
		.stall_fetch (stall_fetch),
		.lookup_pc (lookup_pc),
		.lookup_taken (lookup_taken),
		.group_valid (group_valid),
		.pc_to_dec (pc_to_dec),
		.inst_to_dec (inst_to_dec),
		.slot_valid (slot_valid),
		.pred_result_to_dec (pred_result_to_dec)
	);

endmodule

//--- dv/fetch_asserts.sv
`timescale 1ns/1ps

module fetch_asserts #(
	parameter int IMEM_ADDR_W = 10
) (
	input logic clk,
	input logic rst,
	input logic host_psel,
	input logic host_pready,
	input logic fetch_psel,
	input logic fetch_pready,
	input logic mem_psel,
	input logic mem_penable,
	input logic mem_pwrite,
	input logic [IMEM_ADDR_W-1:0] mem_paddr,
	input logic mem_pready
);

	int fail_count = 0;
	// cycles each requester has been left waiting
	int host_wait;
	int fetch_wait;

	always_ff @(posedge clk) begin
		if (rst || !host_psel || host_pready) begin
			host_wait <= 0;
		end else begin
			host_wait <= host_wait + 1;
		end
		if (rst || !fetch_psel || fetch_pready) begin
			fetch_wait <= 0;
		end else begin
			fetch_wait <= fetch_wait + 1;
		end
	end

	//////////////////////////////
	// arbitration
	//////////////////////////////

	// a completion goes to one side only, and only to a side that is asking
	assert property (@(posedge clk) disable iff (rst)
		!(host_pready && fetch_pready)
		&& (!host_pready || host_psel) && (!fetch_pready || fetch_psel))
		else begin
			$error("completion granted to both requesters or to an idle one");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (rst) host_wait < 8 && fetch_wait < 8)
		else begin
			$error("held request not answered within 8 cycles");
			fail_count++;
		end

	//////////////////////////////
	// memory side APB
	//////////////////////////////

	// every setup cycle is followed by its access cycle
	assert property (@(posedge clk) disable iff (rst)
		mem_psel && !mem_penable |=> mem_psel && mem_penable)
		else begin
			$error("setup cycle not followed by an access cycle");
			fail_count++;
		end

	// address and direction held until the completer answers
	assert property (@(posedge clk) disable iff (rst)
		mem_psel && !mem_pready |=> $stable(mem_paddr) && $stable(mem_pwrite))
		else begin
			$error("paddr or pwrite moved during a transfer");
			fail_count++;
		end

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
	import fetch_pkg::*;

	localparam int IMEM_ADDR_W = 10;
	localparam int PRED_ENTRIES = 64;
	localparam int IDX_W = $clog2(PRED_ENTRIES);
	localparam int PROG_GROUPS = 64;
	localparam int PROG_WORDS = PROG_GROUPS * GROUP_SLOTS;
	localparam int RUN_CYCLES = 4000;
	localparam int HOST_TIMEOUT = 20;
	localparam int GROUP_TIMEOUT = 60;

	logic clk = 1'b0;
	logic rst;
	logic host_psel;
	logic host_penable;
	logic host_pwrite;
	logic [IMEM_ADDR_W-1:0] host_paddr;
	group_t host_pwdata;
	group_t host_prdata;
	logic host_pready;
	pc_t exter_pc;
	logic exter_pc_en;
	logic has_mispredict;
	pc_t pc_recovery;
	logic upd_en;
	pc_t upd_pc;
	logic upd_taken;
	logic stall_fetch;
	logic group_valid;
	pc_t pc_to_dec;
	group_t inst_to_dec;
	logic [GROUP_SLOTS-1:0] slot_valid;
	logic [GROUP_SLOTS-1:0] pred_result_to_dec;

	// reference model state
	group_t prog [PROG_GROUPS];
	ctr_t tbl [PRED_ENTRIES];
	pc_t exp_pc;
	logic model_run;
	logic gv_prev;
	pc_t hold_pc;
	group_t hold_inst;
	logic [GROUP_SLOTS-1:0] hold_sv;
	logic [GROUP_SLOTS-1:0] hold_pr;
	int idle_cnt;
	int arrivals;
	// random core stimulus on or off
	logic core_rand;
	logic host_done;
	group_t host_rdata_q;

	always #5 clk = ~clk;

	fetch_top #(
		.IMEM_ADDR_W (IMEM_ADDR_W),
		.PRED_ENTRIES (PRED_ENTRIES)
	) UUT (
		.clk (clk),
		.rst (rst),
		.host_psel (host_psel),
		.host_penable (host_penable),
		.host_pwrite (host_pwrite),
		.host_paddr (host_paddr),
		.host_pwdata (host_pwdata),
		.host_prdata (host_prdata),
		.host_pready (host_pready),
		.exter_pc (exter_pc),
		.exter_pc_en (exter_pc_en),
		.has_mispredict (has_mispredict),
		.pc_recovery (pc_recovery),
		.upd_en (upd_en),
		.upd_pc (upd_pc),
		.upd_taken (upd_taken),
		.stall_fetch (stall_fetch),
		.group_valid (group_valid),
		.pc_to_dec (pc_to_dec),
		.inst_to_dec (inst_to_dec),
		.slot_valid (slot_valid),
		.pred_result_to_dec (pred_result_to_dec)
	);

	bind imem_arbiter fetch_asserts #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_asserts (
		.clk (clk),
		.rst (rst),
		.host_psel (host.psel),
		.host_pready (host.pready),
		.fetch_psel (fetch.psel),
		.fetch_pready (fetch.pready),
		.mem_psel (mem.psel),
		.mem_penable (mem.penable),
		.mem_pwrite (mem.pwrite),
		.mem_paddr (mem.paddr),
		.mem_pready (mem.pready)
	);

	// host pready is combinational, so catch it on the completing edge
	always @(posedge clk) begin
		host_done <= host_pready;
		host_rdata_q <= host_prdata;
	end

	//////////////////////////////
	// reporting
	//////////////////////////////

	task automatic fail_now(input string what);
		$display("error: %s", what);
		$display(">>> FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			$display(">>> FAIL");
			$fatal(1, "stopping at first error");
		end
	endtask

	//////////////////////////////
	// program and group model
	//////////////////////////////

	task automatic build_program();
		int p;
		int r;
		int lo;
		int hi;
		inst_t w;
		for (p = 0; p < PROG_WORDS; p++) begin
			r = int'($urandom_range(0, 99));
			// first four groups stay free of control flow
			if (p < 16 || r >= 20) begin
				// any opcode but branch and jump
				r = int'($urandom_range(0, 13));
				if (r >= 11) r++;
				if (r >= 14) r++;
				w = {4'(r), 12'($urandom)};
			end else if (r < 15) begin
				// keep the target inside the program
				lo = (p < 128) ? -p : -128;
				hi = (p > 128) ? 255 - p : 127;
				r = lo + int'($urandom_range(0, 32'(hi - lo)));
				w = {OP_BRANCH, 4'($urandom), 8'(r)};
			end else begin
				w = {OP_JUMP, 12'($urandom_range(0, PROG_WORDS - 1))};
			end
			// last word jumps back, no fall-through past the program
			if (p == PROG_WORDS - 1) w = {OP_JUMP, 12'($urandom_range(0, PROG_WORDS - 1))};
			prog[p / GROUP_SLOTS][p % GROUP_SLOTS] = w;
		end
	endtask

	task automatic predict_group(input pc_t pc, output group_t grp,
			output logic [GROUP_SLOTS-1:0] sv, output logic [GROUP_SLOTS-1:0] pr,
			output pc_t nxt);
		pc_t base;
		pc_t spc;
		inst_t w;
		int i;
		logic done;
		assert (pc < pc_t'(PROG_WORDS)) else fail_now("fetch left the loaded program");
		base = pc & 16'hfffc;
		grp = prog[base[7:2]];
		sv = '0;
		pr = '0;
		nxt = base + 16'd4;
		done = 1'b0;
		// walk from the entry slot until something redirects
		for (i = int'(pc[1:0]); i < GROUP_SLOTS && !done; i++) begin
			spc = base + pc_t'(i);
			w = grp[i];
			sv[i] = 1'b1;
			if (w[15:12] == OP_JUMP) begin
				nxt = {spc[15:12], w[11:0]};
				done = 1'b1;
			end else if (w[15:12] == OP_BRANCH && tbl[spc[IDX_W-1:0]] >= 2'd2) begin
				pr[i] = 1'b1;
				nxt = pc_t'(int'(spc) + int'($signed(w[7:0])));
				done = 1'b1;
			end
		end
	endtask

	//////////////////////////////
	// per cycle monitor
	//////////////////////////////

	// runs at the falling edge, inputs still hold last cycle's values
	task automatic monitor();
		group_t m_grp;
		logic [GROUP_SLOTS-1:0] m_sv;
		logic [GROUP_SLOTS-1:0] m_pr;
		pc_t m_nxt;
		logic redirect;
		logic held;
		redirect = exter_pc_en | has_mispredict;
		held = gv_prev & stall_fetch & !redirect;
		if (held) begin
			check_val("stall valid", 64'(1'b1), 64'(group_valid));
			check_val("stall pc", 64'(hold_pc), 64'(pc_to_dec));
			check_val("stall inst", hold_inst, inst_to_dec);
			check_val("stall slot_valid", 64'(hold_sv), 64'(slot_valid));
			check_val("stall pred_result", 64'(hold_pr), 64'(pred_result_to_dec));
		end else if (group_valid) begin
			// fresh group, uses the counters from before this edge
			assert (model_run) else fail_now("a group arrived before the engine was started");
			predict_group(exp_pc, m_grp, m_sv, m_pr, m_nxt);
			check_val("group pc", 64'(exp_pc & 16'hfffc), 64'(pc_to_dec));
			check_val("group inst", m_grp, inst_to_dec);
			check_val("group slot_valid", 64'(m_sv), 64'(slot_valid));
			check_val("group pred_result", 64'(m_pr), 64'(pred_result_to_dec));
			hold_pc = pc_to_dec;
			hold_inst = inst_to_dec;
			hold_sv = slot_valid;
			hold_pr = pred_result_to_dec;
			exp_pc = m_nxt;
			arrivals++;
			idle_cnt = 0;
		end
		if (redirect) begin
			check_val("redirect drops group", 64'(1'b0), 64'(group_valid));
			exp_pc = exter_pc_en ? exter_pc : pc_recovery;
			model_run = model_run | exter_pc_en;
			idle_cnt = 0;
		end
		if (model_run && !group_valid) begin
			idle_cnt++;
			if (idle_cnt > GROUP_TIMEOUT) fail_now("no fetch group arrived within the timeout");
		end
		// commit update lands on this edge
		if (upd_en) begin
			if (upd_taken && tbl[upd_pc[IDX_W-1:0]] != 2'd3) begin
				tbl[upd_pc[IDX_W-1:0]] = tbl[upd_pc[IDX_W-1:0]] + 2'd1;
			end else if (!upd_taken && tbl[upd_pc[IDX_W-1:0]] != 2'd0) begin
				tbl[upd_pc[IDX_W-1:0]] = tbl[upd_pc[IDX_W-1:0]] - 2'd1;
			end
		end
		gv_prev = group_valid;
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic drive_random();
		stall_fetch = ($urandom_range(0, 99) < 30);
		upd_en = ($urandom_range(0, 99) < 25);
		upd_pc = pc_t'($urandom_range(0, PROG_WORDS - 1));
		upd_taken = ($urandom_range(0, 99) < 60);
		has_mispredict = ($urandom_range(0, 99) < 3);
		pc_recovery = pc_t'($urandom_range(0, PROG_WORDS - 1));
		exter_pc_en = ($urandom_range(0, 199) == 0);
		exter_pc = pc_t'($urandom_range(0, PROG_WORDS - 1));
	endtask

	task automatic cycle();
		@(negedge clk);
		monitor();
		if (core_rand) drive_random();
	endtask

	task automatic host_xfer(input logic wr, input logic [IMEM_ADDR_W-1:0] addr,
			input group_t wdata, output group_t rdata);
		int n;
		// setup
		host_psel = 1'b1;
		host_penable = 1'b0;
		host_pwrite = wr;
		host_paddr = addr;
		host_pwdata = wdata;
		cycle();
		host_penable = 1'b1;
		n = 0;
		while (!host_done) begin
			if (n > HOST_TIMEOUT) fail_now("host transfer never completed");
			cycle();
			n++;
		end
		rdata = host_rdata_q;
		host_psel = 1'b0;
		host_penable = 1'b0;
		host_pwrite = 1'b0;
	endtask

	task automatic wait_groups(input int count);
		int target;
		int n;
		target = arrivals + count;
		n = 0;
		while (arrivals < target) begin
			if (n > GROUP_TIMEOUT * count) fail_now("expected fetch group never arrived");
			cycle();
			n++;
		end
	endtask

	initial begin
		group_t rd;
		int g;
		void'($urandom(32'h4d65_b734));
		rst = 1'b1;
		host_psel = 1'b0;
		host_penable = 1'b0;
		host_pwrite = 1'b0;
		host_paddr = '0;
		host_pwdata = '0;
		exter_pc = '0;
		exter_pc_en = 1'b0;
		has_mispredict = 1'b0;
		pc_recovery = '0;
		upd_en = 1'b0;
		upd_pc = '0;
		upd_taken = 1'b0;
		stall_fetch = 1'b0;
		model_run = 1'b0;
		gv_prev = 1'b0;
		exp_pc = '0;
		idle_cnt = 0;
		arrivals = 0;
		core_rand = 1'b0;
		for (g = 0; g < PRED_ENTRIES; g++) begin
			tbl[g] = 2'd1;
		end
		repeat (10) @(negedge clk);
		rst = 1'b0;

		// load the program, then read all of it back
		build_program();
		for (g = 0; g < PROG_GROUPS; g++) begin
			host_xfer(1'b1, IMEM_ADDR_W'(g), prog[g], rd);
		end
		for (g = 0; g < PROG_GROUPS; g++) begin
			host_xfer(1'b0, IMEM_ADDR_W'(g), '0, rd);
			check_val("readback", prog[g], rd);
		end

		// straight line fetch, entry at slot 1
		exter_pc = 16'd1;
		exter_pc_en = 1'b1;
		cycle();
		exter_pc_en = 1'b0;
		wait_groups(4);

		// everything random, host reads race the engine
		core_rand = 1'b1;
		for (int c = 0; c < RUN_CYCLES; c++) begin
			if ($urandom_range(0, 99) < 5) begin
				g = int'($urandom_range(0, PROG_GROUPS - 1));
				host_xfer(1'b0, IMEM_ADDR_W'(g), '0, rd);
				check_val("contended readback", prog[g], rd);
			end else begin
				cycle();
			end
		end

		// quiet drain
		core_rand = 1'b0;
		stall_fetch = 1'b0;
		upd_en = 1'b0;
		has_mispredict = 1'b0;
		exter_pc_en = 1'b0;
		wait_groups(2);
		$display("groups checked: %0d", arrivals);

		if (UUT.u_arbiter.u_asserts.fail_count == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("bus assertions failed %0d times", UUT.u_arbiter.u_asserts.fail_count);
			$display(">>> FAIL");
			$fatal(1, "bus assertion failures");
		end
	end

endmodule

//--- files.f
logic/fetch_pkg.sv
logic/imem_apb_if.sv
logic/imem_arbiter.sv
logic/imem_bank.sv
logic/branch_predictor.sv
logic/fetch_engine.sv
logic/fetch_top.sv
dv/fetch_asserts.sv
dv/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module fetch_tb -f files.f -o fetch_tb_sim
./obj_dir/fetch_tb_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q ">>> FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
